/* hdl/wdma_cfg.svh */
// sdp write dma widths
`ifndef WDMA_CFG_SVH
`define WDMA_CFG_SVH

// command address, in 16-byte units
`define WDMA_ADDR_W 60

// beat count minus one
`define WDMA_SIZE_W 13

// number of data fifos feeding the output
`define WDMA_LANES 4

// one fifo word, one atom
`define WDMA_ATOM_W 128

// dma write request payload, kind bit on top
`define WDMA_REQ_W 130

// command word: addr, size, odd, cube_end (msb)
// odd sits below cube_end and is not used here
`define WDMA_CMD_PD_W (`WDMA_ADDR_W + `WDMA_SIZE_W + 2)

`endif

/* hdl/wdma_pkg.sv */
// sdp write dma types
package wdma_pkg;

  // output phase, command packet first then data beats
  typedef enum logic {
    PHASE_CMD,
    PHASE_DAT
  } wdma_phase_e;

  // request kind, top bit of the dma packet
  typedef enum logic {
    PKT_CMD = 1'b0,
    PKT_DAT = 1'b1
  } wdma_pkt_e;

  // element-wise alu operation
  typedef enum logic [1:0] {
    ALU_MAX,
    ALU_MIN,
    ALU_SUM,
    ALU_EQL = 2'd3
  } wdma_alu_algo_e;

  // command packet fields
  localparam int CMD_ADDR_LSB = 0;
  localparam int CMD_SIZE_LSB = 64;
  localparam int CMD_ACK_BIT  = 77;

  // data packet mask, lane 0 only
  localparam int DAT_MASK_BIT = 128;

  // shared by both kinds
  localparam int PKT_KIND_BIT = 129;

  // 16-byte units to byte address
  localparam int ADDR_SHIFT = 4;

endpackage

/* hdl/wdma_if.sv */
// write dma internal buses
`timescale 1ns/10ps
`include "wdma_cfg.svh"

// ==========================================================================
// command path
// ==========================================================================
interface wdma_cmd_if;
  wdma_pkg::wdma_phase_e   phase;
  logic                    cmd_vld;
  logic [`WDMA_ADDR_W-1:0] cmd_addr;
  logic [`WDMA_SIZE_W-1:0] cmd_size;
  logic                    cmd_cube_end;
  // effective ready, quiet mode included
  logic                    wr_rdy;

  modport ctrl (
    output phase, cmd_vld, cmd_addr, cmd_size, cmd_cube_end,
    input  wr_rdy
  );

  modport beat (
    input phase, cmd_size, wr_rdy
  );

  modport pack (
    input  phase, cmd_vld, cmd_addr, cmd_size, cmd_cube_end,
    output wr_rdy
  );
endinterface

// ==========================================================================
// beat path
// ==========================================================================
interface wdma_beat_if;
  logic                    dat_vld;
  logic                    dat_accept;
  logic                    last_beat;
  logic [`WDMA_ATOM_W-1:0] dat_data;
  // one-hot pop request to the fifos
  logic [`WDMA_LANES-1:0]  lane_rdy;

  modport seq (
    output dat_vld, dat_accept, last_beat, dat_data, lane_rdy
  );

  modport ctrl (input dat_accept, last_beat);

  modport pack (input dat_vld, dat_data);

  modport eq (input lane_rdy);
endinterface

/* hdl/wdma_cmd_ctrl.sv */
// write dma command control
`timescale 1ns/10ps
`include "wdma_cfg.svh"

module wdma_cmd_ctrl (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic [`WDMA_CMD_PD_W-1:0] cmd2dat_dma_pd,
  input  logic                      cmd2dat_dma_pvld,
  output logic                      cmd2dat_dma_prdy,
  input  logic                      reg2dp_interrupt_ptr,
  wdma_cmd_if.ctrl                  cmd,
  wdma_beat_if.ctrl                 beat,
  output logic                      dp2reg_done,
  output logic                      intr_req_ptr,
  output logic                      intr_req_pvld
);

  logic cmd_load;
  logic cmd_accept;
  logic cmd_done;
  logic layer_done;

  // ==========================================================================
  // command holding register
  // ==========================================================================
  // free when empty or when its last beat goes out now
  assign cmd_done         = beat.dat_accept & beat.last_beat;
  assign cmd2dat_dma_prdy = cmd_done | ~cmd.cmd_vld;
  assign cmd_load         = cmd2dat_dma_pvld & cmd2dat_dma_prdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cmd.cmd_vld      <= 1'b0;
      cmd.cmd_cube_end <= 1'b0;
    end else if (cmd2dat_dma_prdy) begin
      cmd.cmd_vld <= cmd2dat_dma_pvld;
      if (cmd2dat_dma_pvld) begin
        cmd.cmd_cube_end <= cmd2dat_dma_pd[`WDMA_CMD_PD_W-1];
      end
    end
  end

  // address and size, payload only
  always_ff @(posedge nvdla_core_clk) begin
    if (cmd_load) begin
      cmd.cmd_addr <= cmd2dat_dma_pd[`WDMA_ADDR_W-1:0];
      cmd.cmd_size <= cmd2dat_dma_pd[`WDMA_ADDR_W +: `WDMA_SIZE_W];
    end
  end

  // ==========================================================================
  // output phase
  // ==========================================================================
  // command packet taken by dma, or dropped in quiet mode
  assign cmd_accept = (cmd.phase == wdma_pkg::PHASE_CMD) & cmd.cmd_vld & cmd.wr_rdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cmd.phase <= wdma_pkg::PHASE_CMD;
    end else if (cmd_accept) begin
      cmd.phase <= wdma_pkg::PHASE_DAT;
    end else if (cmd_done) begin
      cmd.phase <= wdma_pkg::PHASE_CMD;
    end
  end

  // ==========================================================================
  // layer done and interrupt
  // ==========================================================================
  // last beat of a cube-end command
  assign layer_done    = cmd_done & cmd.cmd_cube_end;
  assign intr_req_pvld = layer_done;
  assign intr_req_ptr  = reg2dp_interrupt_ptr;

  // done to the register block, one cycle later
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dp2reg_done <= 1'b0;
    end else begin
      dp2reg_done <= layer_done;
    end
  end

endmodule

/* hdl/wdma_beat_seq.sv */
// write dma beat sequencer
`timescale 1ns/10ps
`include "wdma_cfg.svh"

module wdma_beat_seq (
  input  logic                                       nvdla_core_clk,
  input  logic                                       nvdla_core_rstn,
  input  logic [`WDMA_LANES-1:0][`WDMA_ATOM_W-1:0]   dfifo_pd,
  input  logic [`WDMA_LANES-1:0]                     dfifo_pvld,
  wdma_cmd_if.beat                                   cmd,
  wdma_beat_if.seq                                   beat
);

  localparam int LANE_W = $clog2(`WDMA_LANES);

  logic [`WDMA_SIZE_W-1:0] beat_count;
  // one extra bit so size+1 does not wrap
  logic [`WDMA_SIZE_W:0]   beat_count_nxt;
  logic [`WDMA_SIZE_W:0]   size_of_beat;
  logic [LANE_W-1:0]       lane_sel;
  logic                    dat_rdy;

  // ==========================================================================
  // beat counter
  // ==========================================================================
  assign beat_count_nxt = {1'b0, beat_count} + 1'b1;
  assign size_of_beat   = {1'b0, cmd.cmd_size} + 1'b1;
  assign beat.last_beat = (beat_count_nxt == size_of_beat);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      beat_count <= '0;
    end else if (beat.dat_accept) begin
      if (beat.last_beat) begin
        beat_count <= '0;
      end else begin
        beat_count <= beat_count_nxt[`WDMA_SIZE_W-1:0];
      end
    end
  end

  // ==========================================================================
  // lane selection
  // ==========================================================================
  // one atom per beat, lanes taken in turn
  assign lane_sel = beat_count[LANE_W-1:0];

  // pop only in data phase with downstream ready
  assign dat_rdy = (cmd.phase == wdma_pkg::PHASE_DAT) & cmd.wr_rdy;

  always_comb begin
    beat.lane_rdy = '0;
    beat.lane_rdy[lane_sel] = dat_rdy;
  end

  // beat waits on the selected fifo only
  assign beat.dat_vld    = dfifo_pvld[lane_sel];
  assign beat.dat_accept = beat.dat_vld & dat_rdy;

  // ==========================================================================
  // data gathering
  // ==========================================================================
  // word of the current lane, other lanes ignored
  assign beat.dat_data = dfifo_pd[lane_sel];

endmodule

/* hdl/wdma_req_pack.sv */
// write dma request packer
`timescale 1ns/10ps
`include "wdma_cfg.svh"

module wdma_req_pack (
  input  logic                   reg2dp_ew_bypass,
  input  logic                   reg2dp_ew_alu_bypass,
  input  logic [1:0]             reg2dp_ew_alu_algo,
  input  logic                   reg2dp_output_dst,
  input  logic                   dma_wr_req_rdy,
  wdma_cmd_if.pack               cmd,
  wdma_beat_if.pack              beat,
  output logic [`WDMA_REQ_W-1:0] dma_wr_req_pd,
  output logic                   dma_wr_req_vld
);

  localparam int BYTE_ADDR_W = `WDMA_ADDR_W + wdma_pkg::ADDR_SHIFT;

  logic                  mode_eql;
  logic                  mode_pdp;
  logic                  mode_quiet;
  logic                  cmd_phase;
  wdma_pkg::wdma_pkt_e   pkt_kind;

  // ==========================================================================
  // quiet mode
  // ==========================================================================
  // compare only, nothing written back
  assign mode_eql = ~reg2dp_ew_bypass & ~reg2dp_ew_alu_bypass &
                    (wdma_pkg::wdma_alu_algo_e'(reg2dp_ew_alu_algo) == wdma_pkg::ALU_EQL);
  // output goes to pdp instead of memory
  assign mode_pdp   = reg2dp_output_dst;
  assign mode_quiet = mode_eql | mode_pdp;

  // quiet mode drains without waiting for dma
  assign cmd.wr_rdy = dma_wr_req_rdy | mode_quiet;

  // ==========================================================================
  // packet assembly
  // ==========================================================================
  assign cmd_phase = (cmd.phase == wdma_pkg::PHASE_CMD);
  assign pkt_kind  = cmd_phase ? wdma_pkg::PKT_CMD : wdma_pkg::PKT_DAT;

  always_comb begin
    dma_wr_req_pd = '0;
    if (cmd_phase) begin
      // byte address, size, ack on cube end
      dma_wr_req_pd[wdma_pkg::CMD_ADDR_LSB +: BYTE_ADDR_W] =
        {cmd.cmd_addr, {wdma_pkg::ADDR_SHIFT{1'b0}}};
      dma_wr_req_pd[wdma_pkg::CMD_SIZE_LSB +: `WDMA_SIZE_W] = cmd.cmd_size;
      dma_wr_req_pd[wdma_pkg::CMD_ACK_BIT] = cmd.cmd_cube_end;
    end else begin
      dma_wr_req_pd[`WDMA_ATOM_W-1:0] = beat.dat_data;
      // single atom, lane 0 mask
      dma_wr_req_pd[wdma_pkg::DAT_MASK_BIT] = 1'b1;
    end
    dma_wr_req_pd[wdma_pkg::PKT_KIND_BIT] = pkt_kind;
  end

  // nothing leaves in quiet mode
  assign dma_wr_req_vld = (cmd_phase ? cmd.cmd_vld : beat.dat_vld) & ~mode_quiet;

endmodule

/* hdl/wdma_eq_status.sv */
// write dma unequal status
`timescale 1ns/10ps
`include "wdma_cfg.svh"

module wdma_eq_status (
  input  logic                                     nvdla_core_clk,
  input  logic                                     nvdla_core_rstn,
  input  logic                                     op_load,
  wdma_beat_if.eq                                  beat,
  input  logic [`WDMA_LANES-1:0][`WDMA_ATOM_W-1:0] dfifo_pd,
  input  logic [`WDMA_LANES-1:0]                   dfifo_pvld,
  output logic                                     dp2reg_status_unequal
);

  logic [`WDMA_LANES-1:0] lane_unequal;

  // sticky per lane, any non-zero word popped
  for (genvar i = 0; i < `WDMA_LANES; i++) begin : g_lane
    always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
      if (!nvdla_core_rstn) begin
        lane_unequal[i] <= 1'b0;
      end else if (op_load) begin
        lane_unequal[i] <= 1'b0;
      end else if (dfifo_pvld[i] & beat.lane_rdy[i]) begin
        lane_unequal[i] <= lane_unequal[i] | (|dfifo_pd[i]);
      end
    end
  end

  assign dp2reg_status_unequal = |lane_unequal;

endmodule

/* hdl/wdma_dat_out.sv */
// sdp write dma data output
`timescale 1ns/10ps
`include "wdma_cfg.svh"

module wdma_dat_out (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      op_load,
  // command from the command splitter
  input  logic [`WDMA_CMD_PD_W-1:0] cmd2dat_dma_pd,
  input  logic                      cmd2dat_dma_pvld,
  output logic                      cmd2dat_dma_prdy,
  // data fifos
  input  logic [`WDMA_ATOM_W-1:0]   dfifo0_rd_pd,
  input  logic                      dfifo0_rd_pvld,
  output logic                      dfifo0_rd_prdy,
  input  logic [`WDMA_ATOM_W-1:0]   dfifo1_rd_pd,
  input  logic                      dfifo1_rd_pvld,
  output logic                      dfifo1_rd_prdy,
  input  logic [`WDMA_ATOM_W-1:0]   dfifo2_rd_pd,
  input  logic                      dfifo2_rd_pvld,
  output logic                      dfifo2_rd_prdy,
  input  logic [`WDMA_ATOM_W-1:0]   dfifo3_rd_pd,
  input  logic                      dfifo3_rd_pvld,
  output logic                      dfifo3_rd_prdy,
  // dma write request
  output logic [`WDMA_REQ_W-1:0]    dma_wr_req_pd,
  output logic                      dma_wr_req_vld,
  input  logic                      dma_wr_req_rdy,
  // register block
  input  logic                      reg2dp_ew_bypass,
  input  logic                      reg2dp_ew_alu_bypass,
  input  logic [1:0]                reg2dp_ew_alu_algo,
  input  logic                      reg2dp_output_dst,
  input  logic                      reg2dp_interrupt_ptr,
  output logic                      dp2reg_done,
  output logic                      dp2reg_status_unequal,
  // interrupt
  output logic                      intr_req_ptr,
  output logic                      intr_req_pvld
);

  logic [`WDMA_LANES-1:0][`WDMA_ATOM_W-1:0] dfifo_pd;
  logic [`WDMA_LANES-1:0]                   dfifo_pvld;

  wdma_cmd_if  cmd_if ();
  wdma_beat_if beat_if ();

  // ==========================================================================
  // fifo ports to lane arrays
  // ==========================================================================
  assign dfifo_pd   = {dfifo3_rd_pd, dfifo2_rd_pd, dfifo1_rd_pd, dfifo0_rd_pd};
  assign dfifo_pvld = {dfifo3_rd_pvld, dfifo2_rd_pvld, dfifo1_rd_pvld, dfifo0_rd_pvld};
  assign {dfifo3_rd_prdy, dfifo2_rd_prdy, dfifo1_rd_prdy, dfifo0_rd_prdy} = beat_if.lane_rdy;

  // ==========================================================================
  // submodules
  // ==========================================================================
  wdma_cmd_ctrl u_cmd_ctrl (
    .nvdla_core_clk       (nvdla_core_clk),
    .nvdla_core_rstn      (nvdla_core_rstn),
    .cmd2dat_dma_pd       (cmd2dat_dma_pd),
    .cmd2dat_dma_pvld     (cmd2dat_dma_pvld),
    .cmd2dat_dma_prdy     (cmd2dat_dma_prdy),
    .reg2dp_interrupt_ptr (reg2dp_interrupt_ptr),
    .cmd                  (cmd_if.ctrl),
    .beat                 (beat_if.ctrl),
    .dp2reg_done          (dp2reg_done),
    .intr_req_ptr         (intr_req_ptr),
    .intr_req_pvld        (intr_req_pvld)
  );

  wdma_beat_seq u_beat_seq (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .dfifo_pd        (dfifo_pd),
    .dfifo_pvld      (dfifo_pvld),
    .cmd             (cmd_if.beat),
    .beat            (beat_if.seq)
  );

  wdma_req_pack u_req_pack (
    .reg2dp_ew_bypass     (reg2dp_ew_bypass),
    .reg2dp_ew_alu_bypass (reg2dp_ew_alu_bypass),
    .reg2dp_ew_alu_algo   (reg2dp_ew_alu_algo),
    .reg2dp_output_dst    (reg2dp_output_dst),
    .dma_wr_req_rdy       (dma_wr_req_rdy),
    .cmd                  (cmd_if.pack),
    .beat                 (beat_if.pack),
    .dma_wr_req_pd        (dma_wr_req_pd),
    .dma_wr_req_vld       (dma_wr_req_vld)
  );

  // unequal status, counted in every mode
  wdma_eq_status u_eq_status (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .op_load               (op_load),
    .beat                  (beat_if.eq),
    .dfifo_pd              (dfifo_pd),
    .dfifo_pvld            (dfifo_pvld),
    .dp2reg_status_unequal (dp2reg_status_unequal)
  );

endmodule

/* tb/wdma_dat_out_checker.sv */
// write dma output protocol checker
`timescale 1ns/10ps
`include "wdma_cfg.svh"

module wdma_dat_out_checker (
  input logic                   nvdla_core_clk,
  input logic                   nvdla_core_rstn,
  input logic [`WDMA_REQ_W-1:0] dma_wr_req_pd,
  input logic                   dma_wr_req_vld,
  input logic                   dma_wr_req_rdy,
  input logic [`WDMA_LANES-1:0] pop_rdy,
  input logic [`WDMA_LANES-1:0] pop_vld,
  input logic                   intr_req_pvld,
  input logic                   intr_req_ptr,
  input logic                   reg2dp_interrupt_ptr,
  input logic                   dp2reg_done,
  input logic                   reg2dp_ew_bypass,
  input logic                   reg2dp_ew_alu_bypass,
  input logic [1:0]             reg2dp_ew_alu_algo,
  input logic                   reg2dp_output_dst
);

  int unsigned fail_count = 0;
  logic        quiet;
  logic        stalled;

  // equal compare or pooling output writes nothing
  assign quiet = reg2dp_output_dst |
                 (~reg2dp_ew_bypass & ~reg2dp_ew_alu_bypass & (reg2dp_ew_alu_algo == 2'd3));
  assign stalled = dma_wr_req_vld & ~dma_wr_req_rdy;

  // ==========================================================================
  // back-pressure
  // ==========================================================================
  a_pd_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    stalled |=> $stable(dma_wr_req_pd))
    else begin fail_count++; $error("dma payload changed while stalled"); end

  a_no_pop: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    stalled |-> (pop_rdy == '0))
    else begin fail_count++; $error("fifo popped while dma stalled"); end

  a_quiet: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    quiet |-> !dma_wr_req_vld)
    else begin fail_count++; $error("dma request raised in quiet mode"); end

  // ==========================================================================
  // done and interrupt
  // ==========================================================================
  a_intr_on_pop: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    intr_req_pvld |-> |(pop_rdy & pop_vld))
    else begin fail_count++; $error("interrupt without a beat accept"); end

  a_done_follows: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    intr_req_pvld |=> dp2reg_done)
    else begin fail_count++; $error("done missing after interrupt"); end

  a_done_only: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !intr_req_pvld |=> !dp2reg_done)
    else begin fail_count++; $error("done without interrupt"); end

  a_ptr: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    intr_req_ptr == reg2dp_interrupt_ptr)
    else begin fail_count++; $error("interrupt pointer differs from register"); end

endmodule

bind wdma_dat_out wdma_dat_out_checker u_checker (
  .nvdla_core_clk       (nvdla_core_clk),
  .nvdla_core_rstn      (nvdla_core_rstn),
  .dma_wr_req_pd        (dma_wr_req_pd),
  .dma_wr_req_vld       (dma_wr_req_vld),
  .dma_wr_req_rdy       (dma_wr_req_rdy),
  .pop_rdy              ({dfifo3_rd_prdy, dfifo2_rd_prdy, dfifo1_rd_prdy, dfifo0_rd_prdy}),
  .pop_vld              ({dfifo3_rd_pvld, dfifo2_rd_pvld, dfifo1_rd_pvld, dfifo0_rd_pvld}),
  .intr_req_pvld        (intr_req_pvld),
  .intr_req_ptr         (intr_req_ptr),
  .reg2dp_interrupt_ptr (reg2dp_interrupt_ptr),
  .dp2reg_done          (dp2reg_done),
  .reg2dp_ew_bypass     (reg2dp_ew_bypass),
  .reg2dp_ew_alu_bypass (reg2dp_ew_alu_bypass),
  .reg2dp_ew_alu_algo   (reg2dp_ew_alu_algo),
  .reg2dp_output_dst    (reg2dp_output_dst)
);

/* tb/tb_wdma_dat_out.sv */
// write dma data output testbench
`timescale 1ns/10ps
`include "wdma_cfg.svh"

module tb_wdma_dat_out;

  localparam int          PW         = `WDMA_REQ_W;
  localparam int          DEPTH      = 1024;
  localparam int          WAIT_LIMIT = 2000;
  localparam logic [31:0] SEED       = 32'hfdf7089b;

  logic                      nvdla_core_clk;
  logic                      nvdla_core_rstn;
  logic                      op_load;
  logic [`WDMA_CMD_PD_W-1:0] cmd2dat_dma_pd;
  logic                      cmd2dat_dma_pvld;
  logic                      cmd2dat_dma_prdy;
  logic [`WDMA_ATOM_W-1:0]   fifo_pd [4];
  logic                      fifo_pvld [4];
  logic [3:0]                fifo_prdy;
  logic [PW-1:0]             dma_wr_req_pd;
  logic                      dma_wr_req_vld;
  logic                      dma_wr_req_rdy;
  logic                      reg2dp_ew_bypass;
  logic                      reg2dp_ew_alu_bypass;
  logic [1:0]                reg2dp_ew_alu_algo;
  logic                      reg2dp_output_dst;
  logic                      reg2dp_interrupt_ptr;
  logic                      dp2reg_done;
  logic                      dp2reg_status_unequal;
  logic                      intr_req_ptr;
  logic                      intr_req_pvld;

  // fifo model and scoreboard, write side in stimulus, read side in monitor
  logic [`WDMA_ATOM_W-1:0]   fifo_mem [4][DEPTH];
  int                        fifo_wr [4];
  int                        fifo_rd [4];
  logic [PW-1:0]             exp_pkt [DEPTH];
  int                        exp_wr;
  int                        exp_rd;
  int                        cmd_size_q [DEPTH];
  logic                      cmd_cube_q [DEPTH];
  int                        cmd_wr;
  int                        cmd_rd;
  int                        beat_idx;
  logic [31:0]               data_state;
  logic [31:0]               sink_state;
  logic                      hold_rdy_low;
  string                     test_name;

  wdma_dat_out UUT (
    .nvdla_core_clk (nvdla_core_clk), .nvdla_core_rstn (nvdla_core_rstn), .op_load (op_load),
    .cmd2dat_dma_pd (cmd2dat_dma_pd), .cmd2dat_dma_pvld (cmd2dat_dma_pvld),
    .cmd2dat_dma_prdy (cmd2dat_dma_prdy),
    .dfifo0_rd_pd (fifo_pd[0]), .dfifo0_rd_pvld (fifo_pvld[0]), .dfifo0_rd_prdy (fifo_prdy[0]),
    .dfifo1_rd_pd (fifo_pd[1]), .dfifo1_rd_pvld (fifo_pvld[1]), .dfifo1_rd_prdy (fifo_prdy[1]),
    .dfifo2_rd_pd (fifo_pd[2]), .dfifo2_rd_pvld (fifo_pvld[2]), .dfifo2_rd_prdy (fifo_prdy[2]),
    .dfifo3_rd_pd (fifo_pd[3]), .dfifo3_rd_pvld (fifo_pvld[3]), .dfifo3_rd_prdy (fifo_prdy[3]),
    .dma_wr_req_pd (dma_wr_req_pd), .dma_wr_req_vld (dma_wr_req_vld),
    .dma_wr_req_rdy (dma_wr_req_rdy),
    .reg2dp_ew_bypass (reg2dp_ew_bypass), .reg2dp_ew_alu_bypass (reg2dp_ew_alu_bypass),
    .reg2dp_ew_alu_algo (reg2dp_ew_alu_algo), .reg2dp_output_dst (reg2dp_output_dst),
    .reg2dp_interrupt_ptr (reg2dp_interrupt_ptr), .dp2reg_done (dp2reg_done),
    .dp2reg_status_unequal (dp2reg_status_unequal),
    .intr_req_ptr (intr_req_ptr), .intr_req_pvld (intr_req_pvld)
  );

  // ==========================================================================
  // helpers
  // ==========================================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  function automatic logic [31:0] rand_data();
    data_state = xorshift32(data_state);
    return data_state;
  endfunction

  // command packet, address times 16 in bytes
  function automatic logic [PW-1:0] cmd_packet(input logic [`WDMA_ADDR_W-1:0] addr,
                                               input logic [`WDMA_SIZE_W-1:0] size,
                                               input logic cube_end);
    logic [PW-1:0] pkt;
    pkt = '0;
    pkt[wdma_pkg::CMD_ADDR_LSB +: 64] = 64'(addr) * 64'd16;
    pkt[wdma_pkg::CMD_SIZE_LSB +: `WDMA_SIZE_W] = size;
    pkt[wdma_pkg::CMD_ACK_BIT] = cube_end;
    return pkt;
  endfunction

  function automatic logic [PW-1:0] data_packet(input logic [`WDMA_ATOM_W-1:0] word);
    logic [PW-1:0] pkt;
    pkt = '0;
    pkt[`WDMA_ATOM_W-1:0] = word;
    pkt[wdma_pkg::DAT_MASK_BIT] = 1'b1;
    pkt[wdma_pkg::PKT_KIND_BIT] = 1'b1;
    return pkt;
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "testbench stopped");
  endtask

  task automatic check_value(input string name, input logic [PW-1:0] exp, input logic [PW-1:0] act);
    assert (exp === act) else
      report_failure($sformatf("** Error [%s] %s: expected %h, actual %h",
                               test_name, name, exp, act));
  endtask

  // fills the fifos and scoreboard, then hands the command over
  task automatic send_cmd(input logic [`WDMA_ADDR_W-1:0] addr,
                          input logic [`WDMA_SIZE_W-1:0] size, input logic cube_end,
                          input int fill);
    logic [`WDMA_ATOM_W-1:0] word;
    logic                    quiet;
    int                      waited;
    quiet = reg2dp_output_dst |
            (~reg2dp_ew_bypass & ~reg2dp_ew_alu_bypass & (reg2dp_ew_alu_algo == 2'd3));
    cmd_size_q[cmd_wr] = int'(size);
    cmd_cube_q[cmd_wr] = cube_end;
    cmd_wr++;
    if (!quiet) begin
      exp_pkt[exp_wr] = cmd_packet(addr, size, cube_end);
      exp_wr++;
    end
    for (int k = 0; k <= int'(size); k++) begin
      // fill 1 all zero, fill 2 zero but the last beat
      word = {rand_data(), rand_data(), rand_data(), rand_data()};
      if (fill == 1 || (fill == 2 && k != int'(size))) word = '0;
      fifo_mem[k % 4][fifo_wr[k % 4]] = word;
      fifo_wr[k % 4]++;
      if (!quiet) begin
        exp_pkt[exp_wr] = data_packet(word);
        exp_wr++;
      end
    end
    @(negedge nvdla_core_clk);
    cmd2dat_dma_pd   = {cube_end, 1'b0, size, addr};
    cmd2dat_dma_pvld = 1'b1;
    waited = 0;
    @(posedge nvdla_core_clk);
    while (!cmd2dat_dma_prdy) begin
      waited++;
      if (waited > WAIT_LIMIT) report_failure("command was never accepted");
      @(posedge nvdla_core_clk);
    end
    @(negedge nvdla_core_clk);
    cmd2dat_dma_pvld = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (exp_rd != exp_wr || cmd_rd != cmd_wr) begin
      waited++;
      if (waited > WAIT_LIMIT) report_failure("stream did not drain in time");
      @(negedge nvdla_core_clk);
    end
    for (int i = 0; i < 4; i++) check_value("fifo drained", PW'(fifo_wr[i]), PW'(fifo_rd[i]));
  endtask

  task automatic pulse_op_load();
    @(negedge nvdla_core_clk);
    op_load = 1'b1;
    @(negedge nvdla_core_clk);
    op_load = 1'b0;
    @(negedge nvdla_core_clk);
    check_value("unequal after op_load", PW'(0), PW'(dp2reg_status_unequal));
  endtask

  // ==========================================================================
  // clock, fifo drive, sink, monitor
  // ==========================================================================
  initial begin : clock_gen
    nvdla_core_clk = 1'b0;
    forever #2 nvdla_core_clk = ~nvdla_core_clk;
  end

  initial begin : fifo_drive
    for (int i = 0; i < 4; i++) begin
      fifo_pd[i]   = '0;
      fifo_pvld[i] = 1'b0;
    end
    forever begin
      @(negedge nvdla_core_clk);
      for (int i = 0; i < 4; i++) begin
        fifo_pvld[i] = (fifo_rd[i] != fifo_wr[i]);
        fifo_pd[i]   = fifo_mem[i][fifo_rd[i]];
      end
    end
  end

  // random stalls, held low for quiet runs
  initial begin : dma_sink
    dma_wr_req_rdy = 1'b0;
    sink_state = xorshift32(SEED ^ 32'h5a5a5a5a);
    forever begin
      @(negedge nvdla_core_clk);
      sink_state = xorshift32(sink_state);
      dma_wr_req_rdy = ~hold_rdy_low & (sink_state[1:0] != 2'b00);
    end
  end

  initial begin : monitor
    int   lane;
    logic last;
    exp_rd = 0;
    cmd_rd = 0;
    beat_idx = 0;
    for (int i = 0; i < 4; i++) fifo_rd[i] = 0;
    forever begin
      @(posedge nvdla_core_clk);
      if (nvdla_core_rstn) begin
        if (dma_wr_req_vld && dma_wr_req_rdy) begin
          if (exp_rd == exp_wr) report_failure("dma request sent with no packet expected");
          check_value("dma packet", exp_pkt[exp_rd], dma_wr_req_pd);
          exp_rd++;
        end
        lane = -1;
        for (int i = 0; i < 4; i++) if (fifo_prdy[i] && fifo_pvld[i]) lane = i;
        if (lane >= 0) begin
          if (cmd_rd == cmd_wr) report_failure("fifo popped with no command pending");
          check_value("fifo lane", PW'(beat_idx % 4), PW'(lane));
          fifo_rd[lane]++;
          // interrupt only on the last beat of a cube end
          last = (beat_idx == cmd_size_q[cmd_rd]);
          check_value("intr_req_pvld", PW'(last & cmd_cube_q[cmd_rd]), PW'(intr_req_pvld));
          beat_idx = last ? 0 : beat_idx + 1;
          if (last) cmd_rd++;
        end else begin
          check_value("intr_req_pvld idle", PW'(0), PW'(intr_req_pvld));
        end
      end
    end
  end

  initial begin : assertion_watch
    forever begin
      @(negedge nvdla_core_clk);
      if (UUT.u_checker.fail_count != 0) report_failure("a bound assertion failed");
    end
  end

  initial begin : watchdog
    for (int c = 0; c < 20000; c++) @(posedge nvdla_core_clk);
    report_failure("simulation ran past its cycle limit");
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================
  initial begin : stimulus
    logic [31:0] r;
    nvdla_core_rstn = 1'b0;
    op_load = 1'b0;
    cmd2dat_dma_pd = '0;
    cmd2dat_dma_pvld = 1'b0;
    reg2dp_ew_bypass = 1'b0;
    reg2dp_ew_alu_bypass = 1'b0;
    reg2dp_ew_alu_algo = 2'd2;
    reg2dp_output_dst = 1'b0;
    reg2dp_interrupt_ptr = 1'b0;
    hold_rdy_low = 1'b0;
    data_state = SEED;
    exp_wr = 0;
    cmd_wr = 0;
    for (int i = 0; i < 4; i++) fifo_wr[i] = 0;
    test_name = "reset";
    repeat (4) @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    @(negedge nvdla_core_clk);
    check_value("dma_wr_req_vld", PW'(0), PW'(dma_wr_req_vld));
    check_value("cmd2dat_dma_prdy", PW'(1), PW'(cmd2dat_dma_prdy));
    check_value("dp2reg_done", PW'(0), PW'(dp2reg_done));
    check_value("intr_req_pvld", PW'(0), PW'(intr_req_pvld));
    check_value("dp2reg_status_unequal", PW'(0), PW'(dp2reg_status_unequal));

    // back to back commands under random back-pressure
    test_name = "stream";
    for (int i = 0; i < 12; i++) begin
      r = rand_data();
      reg2dp_interrupt_ptr = r[5];
      send_cmd(`WDMA_ADDR_W'({rand_data(), rand_data()}),
               (i == 0) ? '0 : `WDMA_SIZE_W'(r[3:0]), r[4] | (i % 3 == 0), 0);
    end
    wait_idle();

    // equal compare, nothing written, status from the data
    test_name = "quiet equal";
    hold_rdy_low = 1'b1;
    reg2dp_ew_alu_algo = 2'd3;
    pulse_op_load();
    send_cmd(`WDMA_ADDR_W'(rand_data()), 13'd6, 1'b1, 1);
    wait_idle();
    check_value("unequal on zero stream", PW'(0), PW'(dp2reg_status_unequal));
    send_cmd(`WDMA_ADDR_W'(rand_data()), 13'd9, 1'b0, 2);
    wait_idle();
    check_value("unequal on non-zero word", PW'(1), PW'(dp2reg_status_unequal));
    pulse_op_load();

    test_name = "quiet pooling";
    reg2dp_ew_alu_algo = 2'd2;
    reg2dp_output_dst = 1'b1;
    send_cmd(`WDMA_ADDR_W'(rand_data()), 13'd4, 1'b1, 0);
    wait_idle();
    check_value("unequal on pooling stream", PW'(1), PW'(dp2reg_status_unequal));

    test_name = "final stream";
    reg2dp_output_dst = 1'b0;
    hold_rdy_low = 1'b0;
    pulse_op_load();
    send_cmd(`WDMA_ADDR_W'({rand_data(), rand_data()}), 13'd8, 1'b1, 0);
    wait_idle();

    if (UUT.u_checker.fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      report_failure("a bound assertion failed");
    end
  end

endmodule

/* sdp_wdma.f */
+incdir+hdl
hdl/wdma_pkg.sv
hdl/wdma_if.sv
hdl/wdma_cmd_ctrl.sv
hdl/wdma_beat_seq.sv
hdl/wdma_req_pack.sv
hdl/wdma_eq_status.sv
hdl/wdma_dat_out.sv
tb/wdma_dat_out_checker.sv
tb/tb_wdma_dat_out.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, and look for the pass line
verilator --binary --timing --assert --top-module tb_wdma_dat_out -f sdp_wdma.f \
  -o sim_wdma_dat_out &&
  ./obj_dir/sim_wdma_dat_out +verilator+error+limit+100 2>&1 | tee /dev/stderr |
  grep -q "^RESULT: PASS$" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
